// File: hdl/pinmux_pkg.sv
// Shared widths, register map, field positions, tick select type and pad map
package pinmux_pkg;

  // --------------------------------------------------
  // Widths
  // --------------------------------------------------
  localparam int NUM_PADS   = 16;
  localparam int PORT_W     = NUM_PADS;
  localparam int DATA_W     = 32;
  localparam int ADDR_W     = 8;
  localparam int BE_W       = 4;
  localparam int CNT_W      = 16;
  localparam int PRESCALE_W = 10;

  // Register byte addresses
  localparam logic [ADDR_W-1:0] ADDR_GPIO_OUT  = 8'h00;
  localparam logic [ADDR_W-1:0] ADDR_GPIO_DIR  = 8'h04;
  localparam logic [ADDR_W-1:0] ADDR_GPIO_IN   = 8'h08;  // read only
  localparam logic [ADDR_W-1:0] ADDR_FUNC_SEL  = 8'h0C;
  localparam logic [ADDR_W-1:0] ADDR_PULSE_1US = 8'h10;
  localparam logic [ADDR_W-1:0] ADDR_TIMER0    = 8'h14;  // timer n at +4n
  localparam logic [ADDR_W-1:0] ADDR_PWM0      = 8'h1C;  // channel n at +4n
  localparam logic [ADDR_W-1:0] ADDR_IRQ_STAT  = 8'h24;

  // Timer word fields
  localparam int TMR_CMP_LSB = 0;
  localparam int TMR_ENB_BIT = 16;
  localparam int TMR_SEL_LSB = 17;
  localparam int TMR_SEL_W   = 2;

  // PWM word, high time sits in the low half
  localparam int PWM_LOW_LSB = 16;

  // Function select fields
  localparam int FUNC_PWM_LSB  = 0;
  localparam int FUNC_UART_BIT = 8;

  // Timer tick source, code 3 acts as none
  typedef enum logic [1:0] {
    TICK_NONE = 2'd0,
    TICK_US   = 2'd1,
    TICK_MS   = 2'd2
  } tick_sel_t;

  // Pad assignments
  localparam int PAD_UART_RXD = 0;
  localparam int PAD_UART_TXD = 1;
  localparam int PAD_PWM0     = 2;  // channel n on pad 2+n

endpackage

// File: hdl/pinmux_reg.sv
// Register block: bus decode, config storage, readback, ack and IRQ status
`timescale 1ns/1ps

module pinmux_reg #(
  parameter int NUM_TIMERS = 2,
  parameter int NUM_PWM    = 2
) (
  input  logic                                         mclk_i,
  input  logic                                         rst_n_i,
  // Register bus
  input  logic                                         reg_cs_i,
  input  logic                                         reg_wr_i,
  input  logic [pinmux_pkg::ADDR_W-1:0]                reg_addr_i,
  input  logic [pinmux_pkg::DATA_W-1:0]                reg_wdata_i,
  input  logic [pinmux_pkg::BE_W-1:0]                  reg_be_i,
  output logic [pinmux_pkg::DATA_W-1:0]                reg_rdata_o,
  output logic                                         reg_ack_o,
  output logic [NUM_TIMERS-1:0]                        irq_o,
  // GPIO and global config
  input  logic [pinmux_pkg::PORT_W-1:0]                gpio_in_i,
  output logic [pinmux_pkg::PORT_W-1:0]                gpio_out_o,
  output logic [pinmux_pkg::PORT_W-1:0]                gpio_dir_o,
  output logic [pinmux_pkg::DATA_W-1:0]                func_sel_o,
  output logic [pinmux_pkg::PRESCALE_W-1:0]            prescale_o,
  // Timers
  input  logic [NUM_TIMERS-1:0]                        tmr_expire_i,
  output logic [NUM_TIMERS-1:0][pinmux_pkg::CNT_W-1:0] tmr_cmp_o,
  output logic [NUM_TIMERS-1:0]                        tmr_enb_o,
  output pinmux_pkg::tick_sel_t [NUM_TIMERS-1:0]       tmr_sel_o,
  output logic [NUM_TIMERS-1:0]                        tmr_update_o,
  // PWM
  output logic [NUM_PWM-1:0][pinmux_pkg::CNT_W-1:0]    pwm_high_o,
  output logic [NUM_PWM-1:0][pinmux_pkg::CNT_W-1:0]    pwm_low_o,
  output logic [NUM_PWM-1:0]                           pwm_enb_o
);

  import pinmux_pkg::*;

  localparam int TMR_W = TMR_SEL_LSB + TMR_SEL_W;

  // Software visible state
  logic [PORT_W-1:0]                gpio_out_q;
  logic [PORT_W-1:0]                gpio_dir_q;
  logic [DATA_W-1:0]                func_sel_q;
  logic [PRESCALE_W-1:0]            prescale_q;
  logic [NUM_TIMERS-1:0][TMR_W-1:0] tmr_q;
  logic [NUM_PWM-1:0][DATA_W-1:0]   pwm_q;
  logic [NUM_TIMERS-1:0]            irq_stat_q;
  // Bus control
  logic                             ack_q;
  logic [NUM_TIMERS-1:0]            tmr_update_q;
  logic [PORT_W-1:0]                gpio_in_q;
  logic [DATA_W-1:0]                rdata_q;
  // Decode
  logic                             acc_en;
  logic                             wr_en;
  logic [NUM_TIMERS-1:0]            tmr_hit;
  logic [NUM_PWM-1:0]               pwm_hit;
  logic [NUM_TIMERS-1:0]            irq_clr;
  logic [DATA_W-1:0]                rd_mux;

  // Byte lane merge of write data into an old value
  function automatic logic [DATA_W-1:0] be_merge(
    input logic [DATA_W-1:0] old_val,
    input logic [DATA_W-1:0] new_val,
    input logic [BE_W-1:0]   be
  );
    logic [DATA_W-1:0] res;
    res = old_val;
    for (int b = 0; b < BE_W; b++) begin
      if (be[b]) begin
        res[8*b +: 8] = new_val[8*b +: 8];
      end
    end
    return res;
  endfunction

  // --------------------------------------------------
  // Address decode
  // --------------------------------------------------
  // New access only while no ack is out
  assign acc_en = reg_cs_i & ~ack_q;
  assign wr_en  = acc_en & reg_wr_i;

  always_comb begin
    for (int i = 0; i < NUM_TIMERS; i++) begin
      tmr_hit[i] = (reg_addr_i == ADDR_TIMER0 + ADDR_W'(4 * i));
    end
    for (int i = 0; i < NUM_PWM; i++) begin
      pwm_hit[i] = (reg_addr_i == ADDR_PWM0 + ADDR_W'(4 * i));
    end
  end

  // Write one to clear on enabled bytes only
  assign irq_clr = (wr_en && reg_addr_i == ADDR_IRQ_STAT) ?
                   NUM_TIMERS'(be_merge('0, reg_wdata_i, reg_be_i)) : '0;

  // Read data select with 0 for unmapped addresses
  always_comb begin
    case (reg_addr_i)
      ADDR_GPIO_OUT:  rd_mux = DATA_W'(gpio_out_q);
      ADDR_GPIO_DIR:  rd_mux = DATA_W'(gpio_dir_q);
      ADDR_GPIO_IN:   rd_mux = DATA_W'(gpio_in_q);
      ADDR_FUNC_SEL:  rd_mux = func_sel_q;
      ADDR_PULSE_1US: rd_mux = DATA_W'(prescale_q);
      ADDR_IRQ_STAT:  rd_mux = DATA_W'(irq_stat_q);
      default:        rd_mux = '0;
    endcase
    for (int i = 0; i < NUM_TIMERS; i++) begin
      if (tmr_hit[i]) begin
        rd_mux = DATA_W'(tmr_q[i]);
      end
    end
    for (int i = 0; i < NUM_PWM; i++) begin
      if (pwm_hit[i]) begin
        rd_mux = pwm_q[i];
      end
    end
  end

  // --------------------------------------------------
  // Register update
  // --------------------------------------------------
  always_ff @(posedge mclk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      gpio_out_q   <= '0;
      gpio_dir_q   <= '0;
      func_sel_q   <= '0;
      prescale_q   <= '0;
      tmr_q        <= '0;
      pwm_q        <= '0;
      irq_stat_q   <= '0;
      ack_q        <= 1'b0;
      tmr_update_q <= '0;
    end else begin
      // One cycle ack per access
      ack_q        <= acc_en;
      // Timer reload strobe lines up with the ack
      tmr_update_q <= wr_en ? tmr_hit : '0;
      // Sticky status where a new expiry beats the clear
      irq_stat_q   <= (irq_stat_q & ~irq_clr) | tmr_expire_i;
      if (wr_en) begin
        case (reg_addr_i)
          ADDR_GPIO_OUT: gpio_out_q <=
            PORT_W'(be_merge(DATA_W'(gpio_out_q), reg_wdata_i, reg_be_i));
          ADDR_GPIO_DIR: gpio_dir_q <=
            PORT_W'(be_merge(DATA_W'(gpio_dir_q), reg_wdata_i, reg_be_i));
          ADDR_FUNC_SEL: func_sel_q <= be_merge(func_sel_q, reg_wdata_i, reg_be_i);
          ADDR_PULSE_1US: prescale_q <=
            PRESCALE_W'(be_merge(DATA_W'(prescale_q), reg_wdata_i, reg_be_i));
          default: ;
        endcase
        for (int i = 0; i < NUM_TIMERS; i++) begin
          if (tmr_hit[i]) begin
            tmr_q[i] <= TMR_W'(be_merge(DATA_W'(tmr_q[i]), reg_wdata_i, reg_be_i));
          end
        end
        for (int i = 0; i < NUM_PWM; i++) begin
          if (pwm_hit[i]) begin
            pwm_q[i] <= be_merge(pwm_q[i], reg_wdata_i, reg_be_i);
          end
        end
      end
    end
  end

  // Pad sample and read data
  always_ff @(posedge mclk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      gpio_in_q <= '0;
      rdata_q   <= '0;
    end else begin
      gpio_in_q <= gpio_in_i;
      if (acc_en) begin
        rdata_q <= reg_wr_i ? '0 : rd_mux;
      end
    end
  end

  // --------------------------------------------------
  // Field split
  // --------------------------------------------------
  for (genvar i = 0; i < NUM_TIMERS; i++) begin : g_tmr_fld
    assign tmr_cmp_o[i] = tmr_q[i][TMR_CMP_LSB +: CNT_W];
    assign tmr_enb_o[i] = tmr_q[i][TMR_ENB_BIT];
    assign tmr_sel_o[i] = tick_sel_t'(tmr_q[i][TMR_SEL_LSB +: TMR_SEL_W]);
  end

  for (genvar i = 0; i < NUM_PWM; i++) begin : g_pwm_fld
    assign pwm_high_o[i] = pwm_q[i][CNT_W-1:0];
    assign pwm_low_o[i]  = pwm_q[i][PWM_LOW_LSB +: CNT_W];
    // Channel runs when its pad function is selected
    assign pwm_enb_o[i]  = func_sel_q[FUNC_PWM_LSB + i];
  end

  assign reg_rdata_o  = rdata_q;
  assign reg_ack_o    = ack_q;
  assign irq_o        = irq_stat_q;
  assign gpio_out_o   = gpio_out_q;
  assign gpio_dir_o   = gpio_dir_q;
  assign func_sel_o   = func_sel_q;
  assign prescale_o   = prescale_q;
  assign tmr_update_o = tmr_update_q;

endmodule

// File: hdl/tick_gen.sv
// Programmable 1 us tick prescaler and 1 ms tick divider
`timescale 1ns/1ps

module tick_gen #(
  parameter int MS_DIV = 1000
) (
  input  logic                                mclk_i,
  input  logic                                rst_n_i,
  input  logic [pinmux_pkg::PRESCALE_W-1:0]   prescale_i,
  output logic                                tick_us_o,
  output logic                                tick_ms_o
);

  import pinmux_pkg::*;

  // Guard width for a divide by one
  localparam int MS_W = (MS_DIV > 1) ? $clog2(MS_DIV) : 1;

  logic [PRESCALE_W-1:0] us_cnt_q;
  logic [MS_W-1:0]       ms_cnt_q;
  logic                  tick_us_q;
  logic                  tick_ms_q;
  logic                  us_wrap;
  logic                  ms_wrap;

  // Terminal counts, >= covers a lowered prescale
  assign us_wrap = (us_cnt_q >= prescale_i);
  assign ms_wrap = (ms_cnt_q == MS_W'(MS_DIV - 1));

  always_ff @(posedge mclk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      us_cnt_q  <= '0;
      ms_cnt_q  <= '0;
      tick_us_q <= 1'b0;
      tick_ms_q <= 1'b0;
    end else begin
      us_cnt_q  <= us_wrap ? '0 : us_cnt_q + 1'b1;
      tick_us_q <= us_wrap;
      // ms tick shares the cycle of its us tick
      tick_ms_q <= us_wrap & ms_wrap;
      if (us_wrap) begin
        ms_cnt_q <= ms_wrap ? '0 : ms_cnt_q + 1'b1;
      end
    end
  end

  assign tick_us_o = tick_us_q;
  assign tick_ms_o = tick_ms_q;

endmodule

// File: hdl/interval_timer.sv
// Reloading countdown timer on a selectable us or ms tick
`timescale 1ns/1ps

module interval_timer (
  input  logic                           mclk_i,
  input  logic                           rst_n_i,
  input  logic                           tick_us_i,
  input  logic                           tick_ms_i,
  input  logic [pinmux_pkg::CNT_W-1:0]   cmp_i,
  input  logic                           enb_i,
  input  pinmux_pkg::tick_sel_t          sel_i,
  input  logic                           update_i,
  output logic                           expire_o
);

  import pinmux_pkg::*;

  logic [CNT_W-1:0] cnt_q;
  logic             expire_q;
  logic             tick;

  // Tick source, code 3 counts nothing
  always_comb begin
    case (sel_i)
      TICK_US: tick = tick_us_i;
      TICK_MS: tick = tick_ms_i;
      default: tick = 1'b0;
    endcase
  end

  // --------------------------------------------------
  // Countdown, expiry every cmp+1 ticks
  // --------------------------------------------------
  always_ff @(posedge mclk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cnt_q    <= '0;
      expire_q <= 1'b0;
    end else begin
      expire_q <= 1'b0;
      if (update_i || !enb_i) begin
        // Reload on new config or while idle
        cnt_q <= cmp_i;
      end else if (tick) begin
        if (cnt_q == '0) begin
          expire_q <= 1'b1;
          cnt_q    <= cmp_i;
        end else begin
          cnt_q <= cnt_q - 1'b1;
        end
      end
    end
  end

  assign expire_o = expire_q;

endmodule

// File: hdl/pwm_channel.sv
// PWM waveform generator with high and low times in 1 ms ticks
`timescale 1ns/1ps

module pwm_channel (
  input  logic                           mclk_i,
  input  logic                           rst_n_i,
  input  logic                           tick_ms_i,
  input  logic                           enb_i,
  input  logic [pinmux_pkg::CNT_W-1:0]   high_i,
  input  logic [pinmux_pkg::CNT_W-1:0]   low_i,
  output logic                           wave_o
);

  import pinmux_pkg::*;

  logic             phase_q;  // 1 while in the high phase
  logic [CNT_W-1:0] cnt_q;
  logic [CNT_W-1:0] phase_len;
  logic             phase_end;

  // Setting of the current phase
  assign phase_len = phase_q ? high_i : low_i;
  assign phase_end = (cnt_q == phase_len);

  // --------------------------------------------------
  // Phase sequencer
  // --------------------------------------------------
  always_ff @(posedge mclk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      phase_q <= 1'b1;
      cnt_q   <= '0;
    end else if (!enb_i) begin
      // Idle, restart from the high phase
      phase_q <= 1'b1;
      cnt_q   <= '0;
    end else if (tick_ms_i) begin
      if (phase_end) begin
        phase_q <= ~phase_q;
        cnt_q   <= '0;
      end else begin
        cnt_q <= cnt_q + 1'b1;
      end
    end
  end

  // Low whenever the channel is off
  assign wave_o = enb_i & phase_q;

endmodule

// File: hdl/pad_mux.sv
// Per pad output, output enable and input routing with fixed priority
`timescale 1ns/1ps

module pad_mux #(
  parameter int NUM_PWM = 2
) (
  input  logic [pinmux_pkg::DATA_W-1:0]    func_sel_i,
  input  logic [pinmux_pkg::PORT_W-1:0]    gpio_out_i,
  input  logic [pinmux_pkg::PORT_W-1:0]    gpio_dir_i,
  input  logic [NUM_PWM-1:0]               pwm_wave_i,
  input  logic                             uart_txd_i,
  input  logic [pinmux_pkg::NUM_PADS-1:0]  pad_in_i,
  output logic [pinmux_pkg::NUM_PADS-1:0]  pad_out_o,
  output logic [pinmux_pkg::NUM_PADS-1:0]  pad_oen_o,
  output logic [pinmux_pkg::PORT_W-1:0]    gpio_in_o,
  output logic                             uart_rxd_o
);

  import pinmux_pkg::*;

  logic               uart_enb;
  logic [NUM_PWM-1:0] pwm_enb;

  assign uart_enb = func_sel_i[FUNC_UART_BIT];
  assign pwm_enb  = func_sel_i[FUNC_PWM_LSB +: NUM_PWM];

  // --------------------------------------------------
  // Output and enable select
  // --------------------------------------------------
  // Later arms override earlier ones, so the lowest priority goes first
  always_comb begin
    // Undriven by default
    pad_out_o = '0;
    pad_oen_o = '1;

    // GPIO where dir is set
    for (int p = 0; p < NUM_PADS; p++) begin
      if (gpio_dir_i[p]) begin
        pad_out_o[p] = gpio_out_i[p];
        pad_oen_o[p] = 1'b0;
      end
    end

    // UART takes the RXD and TXD pads
    if (uart_enb) begin
      pad_out_o[PAD_UART_TXD] = uart_txd_i;
      pad_oen_o[PAD_UART_TXD] = 1'b0;
      pad_out_o[PAD_UART_RXD] = 1'b0;
      pad_oen_o[PAD_UART_RXD] = 1'b1;
    end

    // PWM has the top priority on its pad
    for (int c = 0; c < NUM_PWM; c++) begin
      if (pwm_enb[c]) begin
        pad_out_o[PAD_PWM0 + c] = pwm_wave_i[c];
        pad_oen_o[PAD_PWM0 + c] = 1'b0;
      end
    end
  end

  // --------------------------------------------------
  // Input routing
  // --------------------------------------------------
  // GPIO always sees the raw pads
  assign gpio_in_o = pad_in_i;

  // RXD only when UART owns the pad
  assign uart_rxd_o = uart_enb & pad_in_i[PAD_UART_RXD];

endmodule

// File: hdl/pinmux_top.sv
// Pin mux top level: register block, tick generator, timers, PWM and pad mux
`timescale 1ns/1ps

module pinmux_top #(
  parameter int NUM_TIMERS = 2,
  parameter int NUM_PWM    = 2,
  parameter int MS_DIV     = 1000
) (
  input  logic                             mclk_i,
  input  logic                             rst_n_i,
  // Register bus
  input  logic                             reg_cs_i,
  input  logic                             reg_wr_i,
  input  logic [pinmux_pkg::ADDR_W-1:0]    reg_addr_i,
  input  logic [pinmux_pkg::DATA_W-1:0]    reg_wdata_i,
  input  logic [pinmux_pkg::BE_W-1:0]      reg_be_i,
  output logic [pinmux_pkg::DATA_W-1:0]    reg_rdata_o,
  output logic                             reg_ack_o,
  output logic [NUM_TIMERS-1:0]            irq_o,
  // Pads and UART
  input  logic [pinmux_pkg::NUM_PADS-1:0]  pad_in_i,
  output logic [pinmux_pkg::NUM_PADS-1:0]  pad_out_o,
  output logic [pinmux_pkg::NUM_PADS-1:0]  pad_oen_o,
  input  logic                             uart_txd_i,
  output logic                             uart_rxd_o
);

  import pinmux_pkg::*;

  // Config from the register block
  logic [PORT_W-1:0]                gpio_out;
  logic [PORT_W-1:0]                gpio_dir;
  logic [PORT_W-1:0]                gpio_in;
  logic [DATA_W-1:0]                func_sel;
  logic [PRESCALE_W-1:0]            prescale;
  // Ticks
  logic                             tick_us;
  logic                             tick_ms;
  // Timers
  logic [NUM_TIMERS-1:0][CNT_W-1:0] tmr_cmp;
  logic [NUM_TIMERS-1:0]            tmr_enb;
  tick_sel_t [NUM_TIMERS-1:0]       tmr_sel;
  logic [NUM_TIMERS-1:0]            tmr_update;
  logic [NUM_TIMERS-1:0]            tmr_expire;
  // PWM
  logic [NUM_PWM-1:0][CNT_W-1:0]    pwm_high;
  logic [NUM_PWM-1:0][CNT_W-1:0]    pwm_low;
  logic [NUM_PWM-1:0]               pwm_enb;
  logic [NUM_PWM-1:0]               pwm_wave;

  // --------------------------------------------------
  // Decode stage
  // --------------------------------------------------
  pinmux_reg #(
    .NUM_TIMERS (NUM_TIMERS),
    .NUM_PWM    (NUM_PWM)
  ) u_pinmux_reg (
    .mclk_i       (mclk_i),
    .rst_n_i      (rst_n_i),
    .reg_cs_i     (reg_cs_i),
    .reg_wr_i     (reg_wr_i),
    .reg_addr_i   (reg_addr_i),
    .reg_wdata_i  (reg_wdata_i),
    .reg_be_i     (reg_be_i),
    .reg_rdata_o  (reg_rdata_o),
    .reg_ack_o    (reg_ack_o),
    .irq_o        (irq_o),
    .gpio_in_i    (gpio_in),
    .gpio_out_o   (gpio_out),
    .gpio_dir_o   (gpio_dir),
    .func_sel_o   (func_sel),
    .prescale_o   (prescale),
    .tmr_expire_i (tmr_expire),
    .tmr_cmp_o    (tmr_cmp),
    .tmr_enb_o    (tmr_enb),
    .tmr_sel_o    (tmr_sel),
    .tmr_update_o (tmr_update),
    .pwm_high_o   (pwm_high),
    .pwm_low_o    (pwm_low),
    .pwm_enb_o    (pwm_enb)
  );

  // --------------------------------------------------
  // Execute stage
  // --------------------------------------------------
  tick_gen #(
    .MS_DIV (MS_DIV)
  ) u_tick_gen (
    .mclk_i     (mclk_i),
    .rst_n_i    (rst_n_i),
    .prescale_i (prescale),
    .tick_us_o  (tick_us),
    .tick_ms_o  (tick_ms)
  );

  for (genvar i = 0; i < NUM_TIMERS; i++) begin : g_tmr
    interval_timer u_interval_timer (
      .mclk_i    (mclk_i),
      .rst_n_i   (rst_n_i),
      .tick_us_i (tick_us),
      .tick_ms_i (tick_ms),
      .cmp_i     (tmr_cmp[i]),
      .enb_i     (tmr_enb[i]),
      .sel_i     (tmr_sel[i]),
      .update_i  (tmr_update[i]),
      .expire_o  (tmr_expire[i])
    );
  end

  // PWM runs on ms ticks only
  for (genvar i = 0; i < NUM_PWM; i++) begin : g_pwm
    pwm_channel u_pwm_channel (
      .mclk_i    (mclk_i),
      .rst_n_i   (rst_n_i),
      .tick_ms_i (tick_ms),
      .enb_i     (pwm_enb[i]),
      .high_i    (pwm_high[i]),
      .low_i     (pwm_low[i]),
      .wave_o    (pwm_wave[i])
    );
  end

  // --------------------------------------------------
  // Result stage
  // --------------------------------------------------
  pad_mux #(
    .NUM_PWM (NUM_PWM)
  ) u_pad_mux (
    .func_sel_i (func_sel),
    .gpio_out_i (gpio_out),
    .gpio_dir_i (gpio_dir),
    .pwm_wave_i (pwm_wave),
    .uart_txd_i (uart_txd_i),
    .pad_in_i   (pad_in_i),
    .pad_out_o  (pad_out_o),
    .pad_oen_o  (pad_oen_o),
    .gpio_in_o  (gpio_in),
    .uart_rxd_o (uart_rxd_o)
  );

endmodule

// File: verif/tb_clk_gen.sv
// Free running testbench clock source
`timescale 1ns/1ps

module tb_clk_gen #(
  parameter real PERIOD_NS = 20.0
) (
  output logic clk_o
);

  initial begin
    clk_o = 1'b0;
  end

  // Half period toggle
  always #(PERIOD_NS / 2.0) clk_o = ~clk_o;

endmodule

// File: verif/pinmux_tb.sv
// Testbench for the pin mux: bus tasks, reference rules, checks and watchdog
`timescale 1ns/1ps

module pinmux_tb;

  import pinmux_pkg::*;

  localparam int NUM_TIMERS = 2;
  localparam int NUM_PWM    = 2;
  localparam int MS_DIV     = 4;
  localparam int PRESCALE   = 4;
  localparam int US_PERIOD  = PRESCALE + 1;
  localparam int MS_PERIOD  = US_PERIOD * MS_DIV;
  localparam int N_RAND     = 24;
  localparam int ACK_LIMIT  = 8;
  localparam int WAIT_LIMIT = 400;
  // Run length in cycles summed over the test phases plus margin
  localparam int RUN_CYCLES = 10 + N_RAND * 12 + 16 * 6 + 8 * 8
                              + 4 * US_PERIOD * 4 + 4 * MS_PERIOD * 4
                              + 4 * (5 * MS_PERIOD) + 1000;

  logic                  mclk;
  logic                  rst_n;
  logic                  reg_cs;
  logic                  reg_wr;
  logic [ADDR_W-1:0]     reg_addr;
  logic [DATA_W-1:0]     reg_wdata;
  logic [BE_W-1:0]       reg_be;
  logic [DATA_W-1:0]     reg_rdata;
  logic                  reg_ack;
  logic [NUM_TIMERS-1:0] irq;
  logic [NUM_PADS-1:0]   pad_in;
  logic [NUM_PADS-1:0]   pad_out;
  logic [NUM_PADS-1:0]   pad_oen;
  logic                  uart_txd;
  logic                  uart_rxd;

  // Reference register state
  logic [PORT_W-1:0]   mdl_out;
  logic [PORT_W-1:0]   mdl_dir;
  logic [DATA_W-1:0]   mdl_func;
  logic [DATA_W-1:0]   mdl_pwm [NUM_PWM];
  logic [31:0]         rng_state;
  int                  errors;
  int                  cyc;
  int                  ack_cyc;

  tb_clk_gen #(.PERIOD_NS(20.0)) u_tb_clk_gen (.clk_o(mclk));

  pinmux_top #(
    .NUM_TIMERS (NUM_TIMERS),
    .NUM_PWM    (NUM_PWM),
    .MS_DIV     (MS_DIV)
  ) u_pinmux_top (
    .mclk_i      (mclk),
    .rst_n_i     (rst_n),
    .reg_cs_i    (reg_cs),
    .reg_wr_i    (reg_wr),
    .reg_addr_i  (reg_addr),
    .reg_wdata_i (reg_wdata),
    .reg_be_i    (reg_be),
    .reg_rdata_o (reg_rdata),
    .reg_ack_o   (reg_ack),
    .irq_o       (irq),
    .pad_in_i    (pad_in),
    .pad_out_o   (pad_out),
    .pad_oen_o   (pad_oen),
    .uart_txd_i  (uart_txd),
    .uart_rxd_o  (uart_rxd)
  );

  always @(posedge mclk) begin
    cyc <= cyc + 1;
  end

  // --------------------------------------------------
  // Helpers
  // --------------------------------------------------
  function automatic logic [31:0] next_rand();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state;
  endfunction

  // Bytes with their enable set take the new data
  function automatic logic [DATA_W-1:0] lane_update(
    input logic [DATA_W-1:0] old_val,
    input logic [DATA_W-1:0] new_val,
    input logic [BE_W-1:0]   be
  );
    logic [DATA_W-1:0] mask;
    mask = {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
    return (old_val & ~mask) | (new_val & mask);
  endfunction

  task automatic check_value(input string name, input logic [31:0] exp_v,
                             input logic [31:0] got_v);
    assert (exp_v === got_v) else begin
      errors++;
      $display("error %s exp %h got %h", name, exp_v, got_v);
    end
  endtask

  task automatic report(input string what);
    errors++;
    $display("%s", what);
  endtask

  // One bus access starting and ending on a falling edge
  task automatic bus_access(input logic wr, input logic [ADDR_W-1:0] addr,
                            input logic [DATA_W-1:0] data, input logic [BE_W-1:0] be,
                            output logic [DATA_W-1:0] rdata);
    int n;
    n         = 0;
    reg_cs    = 1'b1;
    reg_wr    = wr;
    reg_addr  = addr;
    reg_wdata = data;
    reg_be    = be;
    do begin
      @(negedge mclk);
      n++;
    end while (!reg_ack && n < ACK_LIMIT);
    if (!reg_ack) begin
      report("bus access was never acknowledged");
    end
    // Ack exactly one cycle after cs is sampled
    assert (n == 1) else begin
      report("bus acknowledge came late");
    end
    ack_cyc = cyc;
    rdata   = reg_rdata;
    reg_cs  = 1'b0;
    reg_wr  = 1'b0;
    @(negedge mclk);
    check_value("reg_ack_o", 32'h0, reg_ack);
  endtask

  task automatic reg_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
                           input logic [BE_W-1:0] be);
    logic [DATA_W-1:0] dummy;
    bus_access(1'b1, addr, data, be, dummy);
    case (addr)
      ADDR_GPIO_OUT: mdl_out  = lane_update(32'(mdl_out), data, be);
      ADDR_GPIO_DIR: mdl_dir  = lane_update(32'(mdl_dir), data, be);
      ADDR_FUNC_SEL: mdl_func = lane_update(mdl_func, data, be);
      ADDR_PWM0:     mdl_pwm[0] = lane_update(mdl_pwm[0], data, be);
      ADDR_PWM0 + 8'h4: mdl_pwm[1] = lane_update(mdl_pwm[1], data, be);
      default: ;
    endcase
  endtask

  task automatic reg_read(input logic [ADDR_W-1:0] addr, output logic [DATA_W-1:0] data);
    bus_access(1'b0, addr, '0, '0, data);
  endtask

  // Pad priority is PWM then UART then GPIO dir then undriven
  task automatic check_pads();
    logic [NUM_PADS-1:0] exp_out;
    logic [NUM_PADS-1:0] exp_oen;
    logic [NUM_PADS-1:0] cmp_mask;
    exp_out  = '0;
    exp_oen  = '1;
    cmp_mask = '1;
    for (int p = 0; p < NUM_PADS; p++) begin
      if (p >= PAD_PWM0 && p < PAD_PWM0 + NUM_PWM && mdl_func[p - PAD_PWM0]) begin
        cmp_mask[p] = 1'b0;
        exp_oen[p]  = 1'b0;
      end else if (mdl_func[FUNC_UART_BIT] && p == PAD_UART_TXD) begin
        exp_out[p] = uart_txd;
        exp_oen[p] = 1'b0;
      end else if (mdl_func[FUNC_UART_BIT] && p == PAD_UART_RXD) begin
        exp_oen[p] = 1'b1;
      end else if (mdl_dir[p]) begin
        exp_out[p] = mdl_out[p];
        exp_oen[p] = 1'b0;
      end
    end
    check_value("pad_out_o", 32'(exp_out & cmp_mask), 32'(pad_out & cmp_mask));
    check_value("pad_oen_o", 32'(exp_oen), 32'(pad_oen));
  endtask

  // Cycles until an IRQ bit is set
  task automatic wait_irq(input int idx, output int at_cyc);
    int n;
    n = 0;
    while (!irq[idx] && n < WAIT_LIMIT) begin
      @(negedge mclk);
      n++;
    end
    if (!irq[idx]) begin
      report("timer interrupt never arrived");
    end
    at_cyc = cyc;
  endtask

  // Length of the run until pad 2 leaves the given level
  task automatic pad_run(input logic level, output int len);
    len = 0;
    while (pad_out[PAD_PWM0] === level && len < WAIT_LIMIT) begin
      @(negedge mclk);
      len++;
    end
  endtask

  // --------------------------------------------------
  // Watchdog
  // --------------------------------------------------
  initial begin
    #(RUN_CYCLES * 20);
    $display("watchdog expired before the tests completed");
    $display("Simulation finished: FAIL");
    $finish;
  end

  // --------------------------------------------------
  // Stimulus
  // --------------------------------------------------
  initial begin
    logic [DATA_W-1:0] rd;
    logic [DATA_W-1:0] wd;
    logic [BE_W-1:0]   be;
    logic [ADDR_W-1:0] addr;
    int                t0;
    int                t1;
    int                len;
    rng_state = 32'd38;
    errors    = 0;
    cyc       = 0;
    ack_cyc   = 0;
    rst_n     = 1'b0;
    reg_cs    = 1'b0;
    reg_wr    = 1'b0;
    reg_addr  = '0;
    reg_wdata = '0;
    reg_be    = '0;
    pad_in    = '0;
    uart_txd  = 1'b0;
    mdl_out   = '0;
    mdl_dir   = '0;
    mdl_func  = '0;
    mdl_pwm[0] = '0;
    mdl_pwm[1] = '0;
    repeat (10) @(negedge mclk);
    rst_n = 1'b1;
    @(negedge mclk);

    // Reset state
    check_value("pad_oen_o", 32'hffff, 32'(pad_oen));
    check_value("irq_o", 32'h0, 32'(irq));

    // Random register access
    for (int i = 0; i < N_RAND; i++) begin
      case (next_rand() % 4)
        0:       addr = ADDR_GPIO_OUT;
        1:       addr = ADDR_GPIO_DIR;
        2:       addr = ADDR_PWM0;
        default: addr = ADDR_PWM0 + 8'h4;
      endcase
      wd = next_rand();
      be = BE_W'(next_rand() >> 8);
      reg_write(addr, wd, be);
      reg_read(addr, rd);
      case (addr)
        ADDR_GPIO_OUT: check_value("reg_rdata_o", 32'(mdl_out), rd);
        ADDR_GPIO_DIR: check_value("reg_rdata_o", 32'(mdl_dir), rd);
        ADDR_PWM0:     check_value("reg_rdata_o", mdl_pwm[0], rd);
        default:       check_value("reg_rdata_o", mdl_pwm[1], rd);
      endcase
      check_pads();
    end

    // GPIO input readback
    for (int i = 0; i < 8; i++) begin
      pad_in = NUM_PADS'(next_rand() >> 4);
      @(negedge mclk);
      reg_read(ADDR_GPIO_IN, rd);
      check_value("reg_rdata_o", 32'(pad_in), rd);
    end

    // --------------------------------------------------
    // UART alternate function
    // --------------------------------------------------
    reg_write(ADDR_FUNC_SEL, 32'h1 << FUNC_UART_BIT, 4'hf);
    for (int i = 0; i < 8; i++) begin
      uart_txd = 1'(next_rand() >> 16);
      pad_in   = NUM_PADS'(next_rand() >> 4);
      @(negedge mclk);
      check_pads();
      check_value("uart_rxd_o", 32'(pad_in[PAD_UART_RXD]), 32'(uart_rxd));
    end
    reg_write(ADDR_FUNC_SEL, 32'h0, 4'hf);
    pad_in = '1;
    @(negedge mclk);
    check_value("uart_rxd_o", 32'h0, 32'(uart_rxd));
    check_pads();

    // --------------------------------------------------
    // Timers
    // --------------------------------------------------
    reg_write(ADDR_PULSE_1US, PRESCALE, 4'hf);
    reg_write(ADDR_TIMER0, 32'h3 | (32'h1 << TMR_ENB_BIT) | (32'(TICK_US) << TMR_SEL_LSB),
              4'hf);
    t0 = ack_cyc;
    wait_irq(0, t1);
    // First expiry depends on the tick phase at the update
    assert (t1 - t0 >= 4 * US_PERIOD - 2 && t1 - t0 <= 4 * US_PERIOD + 2) else begin
      report("timer 0 first interrupt outside its window");
    end
    t0 = t1;
    reg_write(ADDR_IRQ_STAT, 32'h1, 4'h1);
    check_value("irq_o", 32'h0, 32'(irq));
    wait_irq(0, t1);
    check_value("timer0 interval", 32'(4 * US_PERIOD), 32'(t1 - t0));
    reg_write(ADDR_TIMER0, 32'h0, 4'hf);
    reg_write(ADDR_IRQ_STAT, 32'h3, 4'h1);
    check_value("irq_o", 32'h0, 32'(irq));

    reg_write(ADDR_TIMER0 + 8'h4,
              32'h1 | (32'h1 << TMR_ENB_BIT) | (32'(TICK_MS) << TMR_SEL_LSB), 4'hf);
    wait_irq(1, t0);
    reg_write(ADDR_IRQ_STAT, 32'h2, 4'h1);
    check_value("irq_o", 32'h0, 32'(irq));
    wait_irq(1, t1);
    check_value("timer1 interval", 32'(2 * MS_PERIOD), 32'(t1 - t0));
    reg_write(ADDR_TIMER0 + 8'h4, 32'h0, 4'hf);
    reg_write(ADDR_IRQ_STAT, 32'h3, 4'h1);

    // --------------------------------------------------
    // PWM channel 0
    // --------------------------------------------------
    reg_write(ADDR_PWM0, 32'h1 | (32'h2 << PWM_LOW_LSB), 4'hf);
    reg_write(ADDR_FUNC_SEL, 32'h1, 4'hf);
    check_value("pad_oen_o[2]", 32'h0, 32'(pad_oen[PAD_PWM0]));
    check_pads();
    pad_run(1'b1, len);
    pad_run(1'b0, len);
    pad_run(1'b1, len);
    check_value("pwm high cycles", 32'(2 * MS_PERIOD), 32'(len));
    pad_run(1'b0, len);
    check_value("pwm low cycles", 32'(3 * MS_PERIOD), 32'(len));
    reg_write(ADDR_FUNC_SEL, 32'h0, 4'hf);
    @(negedge mclk);
    check_pads();

    $display("checks failed: %0d", errors);
    if (errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

// File: filelist.f
hdl/pinmux_pkg.sv
hdl/pinmux_reg.sv
hdl/tick_gen.sv
hdl/interval_timer.sv
hdl/pwm_channel.sv
hdl/pad_mux.sv
hdl/pinmux_top.sv
verif/tb_clk_gen.sv
verif/pinmux_tb.sv
